// ==== include/bru_defs.svh ====
`ifndef BRU_DEFS_SVH
`define BRU_DEFS_SVH

// ------------------------------
// datapath

`define XLEN 32                                 // data and address width

// the BTB keeps only the low target bits
`define BRU_TARGET_RANGE_BITS 12

// ------------------------------
// prediction info

`define BTB_PRED_INFO_WIDTH 8                   // one byte per BTB entry

// simple branch accuracy field, bits 3:0
`define SIMPLE_BRANCH_INIT_ACCURACY 4'd15       // fresh simple branch
`define SIMPLE_BRANCH_ACCURACY_THRESHOLD 4'd11  // decay above, train at or below
`define SIMPLE_BRANCH_INACCURACY_PENALTY 4'd4   // cost of a mispredict when trained

`endif

// ==== rtl/bru_branch_resolver.sv ====
`timescale 1ns/1ps

`include "bru_defs.svh"

module bru_branch_resolver
    import core_types_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            valid_in,
    input  bru_op_e                         op,
    input  logic [`XLEN-1:0]                pc,
    input  logic [`XLEN-1:0]                rs1_data,
    input  logic [`XLEN-1:0]                rs2_data,
    input  logic [`XLEN-1:0]                imm,
    input  logic                            is_link_ra,
    input  logic                            is_ret_ra,
    input  logic [`BTB_PRED_INFO_WIDTH-1:0] start_pred_info,
    input  logic                            pred_taken,
    input  logic [`XLEN-1:0]                pred_target,

    output logic                            done_valid,
    output bru_op_e                         done_op,
    output logic [`BTB_PRED_INFO_WIDTH-1:0] done_start_pred_info,
    output logic                            done_is_link_ra,
    output logic                            done_is_ret_ra,
    output logic                            done_taken,
    output logic                            done_mispredict,
    output logic                            done_out_of_range,
    output logic [`XLEN-1:0]                done_target,
    output logic [`XLEN-1:0]                done_link_value
);

    logic               rs_eq;
    logic               rs_lt;
    logic               rs_ltu;
    logic               is_upper;
    logic               taken;
    logic [`XLEN-1:0]   pc_plus_imm;
    logic [`XLEN-1:0]   rs1_plus_imm;
    logic [`XLEN-1:0]   target;
    logic [`XLEN-1:0]   link_value;
    logic               mispredict;
    logic               out_of_range;

    // ------------------------------
    // condition and target

    assign rs_eq  = (rs1_data == rs2_data);
    assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign rs_ltu = (rs1_data < rs2_data);

    assign is_upper     = (op == LUI) || (op == AUIPC);
    assign pc_plus_imm  = pc + imm;
    assign rs1_plus_imm = (rs1_data + imm) & ~`XLEN'd1;    // jalr clears bit 0

    always_comb begin
        case (op)
            BEQ:        taken = rs_eq;
            BNE:        taken = ~rs_eq;
            BLT:        taken = rs_lt;
            BGE:        taken = ~rs_lt;
            BLTU:       taken = rs_ltu;
            BGEU:       taken = ~rs_ltu;
            LUI, AUIPC: taken = 1'b0;
            default:    taken = 1'b1;   // all jumps
        endcase
    end

    always_comb begin
        case (op)
            JALR, C_JALR, C_JR: target = rs1_plus_imm;
            LUI:                target = imm;
            default:            target = pc_plus_imm;  // branches, direct jumps, auipc
        endcase
    end

    // link register value, or the rd result for lui/auipc
    always_comb begin
        case (op)
            JALR, JAL:                link_value = pc + `XLEN'd4;
            C_JALR, C_JAL, C_J, C_JR: link_value = pc + `XLEN'd2;
            default:                  link_value = target;
        endcase
    end

    assign mispredict = ~is_upper
        & ((taken != pred_taken) | (taken & (target != pred_target)));

    assign out_of_range =
        (target[`XLEN-1:`BRU_TARGET_RANGE_BITS] != pc[`XLEN-1:`BRU_TARGET_RANGE_BITS]);

    // ------------------------------
    // done register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_valid        <= 1'b0;
            done_taken        <= 1'b0;
            done_mispredict   <= 1'b0;
            done_out_of_range <= 1'b0;
        end else begin
            done_valid        <= valid_in;
            done_taken        <= valid_in & taken;
            done_mispredict   <= valid_in & mispredict;
            done_out_of_range <= valid_in & out_of_range;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            done_op              <= op;
            done_start_pred_info <= start_pred_info;
            done_is_link_ra      <= is_link_ra;
            done_is_ret_ra       <= is_ret_ra;
            done_target          <= target;
            done_link_value      <= link_value;
        end
    end

    // ------------------------------
    // checks

    a_legal_op: assert property (@(posedge clk) disable iff (!arst_n)
        valid_in |-> !(op inside {4'd10, 4'd11}))
        else $error("unused bru opcode issued");

endmodule

// ==== rtl/bru_pred_info_updater.sv ====
`timescale 1ns/1ps

`include "bru_defs.svh"

module bru_pred_info_updater
    import core_types_pkg::*;
(
    input  bru_op_e                         op,
    input  logic [`BTB_PRED_INFO_WIDTH-1:0] start_pred_info,
    input  logic                            is_link_ra,
    input  logic                            is_ret_ra,
    input  logic                            is_taken,
    input  logic                            is_mispredict,
    input  logic                            is_out_of_range,

    output logic [`BTB_PRED_INFO_WIDTH-1:0] updated_pred_info
);

    // fresh complex entry, slightly favoring local
    localparam logic [`BTB_PRED_INFO_WIDTH-1:0] COMPLEX_INIT = {COMPLEX_BRANCH, 2'b01, 4'h0};

    pred_type_e                      start_type;
    logic [1:0]                      start_2bc;
    logic [3:0]                      accuracy;
    logic [4:0]                      acc_minus_penalty;  // bit 4 flags underflow
    logic [1:0]                      next_2bc;
    logic                            is_branch;
    logic [`BTB_PRED_INFO_WIDTH-1:0] jump_info;
    logic [`BTB_PRED_INFO_WIDTH-1:0] branch_info;

    assign start_type = pred_type_e'(start_pred_info[7:6]);
    assign start_2bc  = start_pred_info[5:4];
    assign accuracy   = start_pred_info[3:0];
    assign is_branch  = op[3];

    assign acc_minus_penalty = {1'b0, accuracy} - {1'b0, `SIMPLE_BRANCH_INACCURACY_PENALTY};

    // 2bc jumps to the strong end, except leaving a strong state
    always_comb begin
        if (is_taken) begin
            next_2bc = (start_2bc == 2'b00) ? 2'b01 : 2'b11;
        end else begin
            next_2bc = (start_2bc == 2'b11) ? 2'b10 : 2'b00;
        end
    end

    // ------------------------------
    // jumps and upper immediates

    // static encoding, start info is ignored
    always_comb begin
        jump_info      = '0;
        jump_info[7:6] = JUMP;
        case (op)
            JALR: begin
                jump_info[5]   = is_ret_ra;
                jump_info[4:3] = is_link_ra ? 2'b11 : 2'b00;
            end
            C_JALR: begin
                jump_info[5]   = is_ret_ra;
                jump_info[4:3] = is_link_ra ? 2'b10 : 2'b00;   // compressed link
            end
            JAL: begin
                jump_info[4:3] = is_link_ra ? 2'b11 : 2'b00;
            end
            C_JAL: begin
                jump_info[4:3] = is_link_ra ? 2'b10 : 2'b00;
            end
            C_JR: begin
                jump_info[5] = is_ret_ra;
            end
            C_J: begin
                jump_info[5:0] = 6'b0;  // plain jump entry
            end
            default: begin
                jump_info = '0;     // lui, auipc
            end
        endcase
    end

    // ------------------------------
    // branches

    always_comb begin
        branch_info = '0;
        if ((start_type != COMPLEX_BRANCH) && is_out_of_range) begin
            branch_info = COMPLEX_INIT;     // btb cannot hold the target
        end else if ((start_type == INVALID) || (start_type == JUMP)) begin
            branch_info[7:6] = SIMPLE_BRANCH;
            branch_info[5:4] = is_taken ? 2'b11 : 2'b00;
            branch_info[3:0] = `SIMPLE_BRANCH_INIT_ACCURACY;
        end else if (start_type == SIMPLE_BRANCH) begin
            branch_info[7:6] = SIMPLE_BRANCH;
            branch_info[5:4] = next_2bc;
            if (accuracy > `SIMPLE_BRANCH_ACCURACY_THRESHOLD) begin
                branch_info[3:0] = accuracy - 4'd1;     // decay toward threshold
            end else if (is_mispredict && acc_minus_penalty[4]) begin
                branch_info = COMPLEX_INIT;     // out of accuracy, give up on simple
            end else if (is_mispredict) begin
                branch_info[3:0] = acc_minus_penalty[3:0];
            end else if (accuracy == `SIMPLE_BRANCH_ACCURACY_THRESHOLD) begin
                branch_info[3:0] = `SIMPLE_BRANCH_ACCURACY_THRESHOLD;   // saturate
            end else begin
                branch_info[3:0] = accuracy + 4'd1;
            end
        end else begin
            // complex entry, frontend updates its own 2bc
            branch_info = {COMPLEX_BRANCH, start_2bc, 4'h0};
        end
    end

    assign updated_pred_info = is_branch ? branch_info : jump_info;

endmodule

// ==== rtl/bru_top.sv ====
`timescale 1ns/1ps

`include "bru_defs.svh"

module bru_top
    import core_types_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            valid_in,
    input  bru_op_e                         op,
    input  logic [`XLEN-1:0]                pc,
    input  logic [`XLEN-1:0]                rs1_data,
    input  logic [`XLEN-1:0]                rs2_data,
    input  logic [`XLEN-1:0]                imm,
    input  logic                            is_link_ra,
    input  logic                            is_ret_ra,
    input  logic [`BTB_PRED_INFO_WIDTH-1:0] start_pred_info,
    input  logic                            pred_taken,
    input  logic [`XLEN-1:0]                pred_target,

    output logic                            done_valid,
    output logic                            done_taken,
    output logic                            done_mispredict,
    output logic                            done_out_of_range,
    output logic [`XLEN-1:0]                done_target,
    output logic [`XLEN-1:0]                done_link_value,
    output logic [`BTB_PRED_INFO_WIDTH-1:0] updated_pred_info
);

    // ------------------------------
    // resolver to updater

    bru_op_e                         done_op;
    logic [`BTB_PRED_INFO_WIDTH-1:0] done_start_pred_info;
    logic                            done_is_link_ra;
    logic                            done_is_ret_ra;

    bru_branch_resolver resolver0 (
        .clk                  (clk),
        .arst_n               (arst_n),
        .valid_in             (valid_in),
        .op                   (op),
        .pc                   (pc),
        .rs1_data             (rs1_data),
        .rs2_data             (rs2_data),
        .imm                  (imm),
        .is_link_ra           (is_link_ra),
        .is_ret_ra            (is_ret_ra),
        .start_pred_info      (start_pred_info),
        .pred_taken           (pred_taken),
        .pred_target          (pred_target),
        .done_valid           (done_valid),
        .done_op              (done_op),
        .done_start_pred_info (done_start_pred_info),
        .done_is_link_ra      (done_is_link_ra),
        .done_is_ret_ra       (done_is_ret_ra),
        .done_taken           (done_taken),
        .done_mispredict      (done_mispredict),
        .done_out_of_range    (done_out_of_range),
        .done_target          (done_target),
        .done_link_value      (done_link_value)
    );

    bru_pred_info_updater updater0 (
        .op                (done_op),
        .start_pred_info   (done_start_pred_info),
        .is_link_ra        (done_is_link_ra),
        .is_ret_ra         (done_is_ret_ra),
        .is_taken          (done_taken),
        .is_mispredict     (done_mispredict),
        .is_out_of_range   (done_out_of_range),
        .updated_pred_info (updated_pred_info)
    );

    // a resolved branch always leaves a branch entry in the btb
    a_branch_entry_type: assert property (@(posedge clk) disable iff (!arst_n)
        (done_valid && done_op[3]) |->
            (pred_type_e'(updated_pred_info[7:6]) inside {SIMPLE_BRANCH, COMPLEX_BRANCH}))
        else $error("branch resolved to a non-branch btb entry");

endmodule

// ==== rtl/core_types_pkg.sv ====
package core_types_pkg;

    // ------------------------------
    // BRU opcodes

    // bit 3 set marks a conditional branch
    typedef enum logic [3:0] {
        JALR   = 4'd0,
        C_JALR = 4'd1,
        JAL    = 4'd2,
        C_JAL  = 4'd3,
        C_J    = 4'd4,
        C_JR   = 4'd5,
        LUI    = 4'd6,
        AUIPC  = 4'd7,
        BEQ    = 4'd8,
        BNE    = 4'd9,
        // 10 and 11 are unused
        BLT    = 4'd12,
        BGE    = 4'd13,
        BLTU   = 4'd14,
        BGEU   = 4'd15
    } bru_op_e;

    // ------------------------------
    // prediction info entry type, bits 7:6

    typedef enum logic [1:0] {
        INVALID        = 2'd0,
        JUMP           = 2'd1,
        SIMPLE_BRANCH  = 2'd2,
        COMPLEX_BRANCH = 2'd3
    } pred_type_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BRU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_bru_top \
    -Mdir obj_dir -o tb_bru_top
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_bru_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Done: errors found" "$LOG" || [ $status -ne 0 ]; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

// ==== sim/tb_bru_top.sv ====
`timescale 1ns/1ps

`include "bru_defs.svh"

module tb_bru_top
    import core_types_pkg::*;
();

    localparam int NUM_INSTR  = 3000;
    localparam int MAX_CYCLES = NUM_INSTR * 5 / 3;  // ~4000 at 75% issue, plus margin

    logic                            clk;
    logic                            arst_n;
    logic                            valid_in;
    bru_op_e                         op;
    logic [`XLEN-1:0]                pc;
    logic [`XLEN-1:0]                rs1_data;
    logic [`XLEN-1:0]                rs2_data;
    logic [`XLEN-1:0]                imm;
    logic                            is_link_ra;
    logic                            is_ret_ra;
    logic [`BTB_PRED_INFO_WIDTH-1:0] start_pred_info;
    logic                            pred_taken;
    logic [`XLEN-1:0]                pred_target;
    logic                            done_valid;
    logic                            done_taken;
    logic                            done_mispredict;
    logic                            done_out_of_range;
    logic [`XLEN-1:0]                done_target;
    logic [`XLEN-1:0]                done_link_value;
    logic [`BTB_PRED_INFO_WIDTH-1:0] updated_pred_info;

    // expected result of the instruction issued last cycle
    logic                            exp_valid;
    bru_op_e                         exp_op;
    logic                            exp_taken;
    logic                            exp_mispredict;
    logic                            exp_out_of_range;
    logic [`XLEN-1:0]                exp_target;
    logic [`XLEN-1:0]                exp_link;
    logic [`BTB_PRED_INFO_WIDTH-1:0] exp_info;

    bru_op_e     legal_ops [0:13];
    int          errors;
    int          issued;
    int          cycles;
    int unsigned seed_val;

    bru_top dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "simulation stopped on timeout");
        end else begin
            cycles <= cycles + 1;
        end
    end

    // ------------------------------
    // reference model

    function automatic logic is_branch_op(bru_op_e o);
        return o inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    function automatic logic model_taken(bru_op_e o, logic [31:0] a, logic [31:0] b);
        case (o)
            BEQ:        return a == b;
            BNE:        return a != b;
            BLT:        return $signed(a) < $signed(b);
            BGE:        return $signed(a) >= $signed(b);
            BLTU:       return a < b;
            BGEU:       return a >= b;
            LUI, AUIPC: return 1'b0;
            default:    return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] model_target(bru_op_e o, logic [31:0] p,
                                                 logic [31:0] a, logic [31:0] i);
        if (o inside {JALR, C_JALR, C_JR})
            return (a + i) & 32'hFFFF_FFFE;
        if (o == LUI)
            return i;
        return p + i;
    endfunction

    function automatic logic [7:0] jump_info_model(bru_op_e o, logic link, logic ret);
        case (o)
            JALR:    return {JUMP, ret, link ? 2'b11 : 2'b00, 3'b000};
            C_JALR:  return {JUMP, ret, link ? 2'b10 : 2'b00, 3'b000};
            JAL:     return {JUMP, 1'b0, link ? 2'b11 : 2'b00, 3'b000};
            C_JAL:   return {JUMP, 1'b0, link ? 2'b10 : 2'b00, 3'b000};
            C_JR:    return {JUMP, ret, 5'b00000};
            C_J:     return 8'h40;
            default: return 8'h00;  // lui, auipc
        endcase
    endfunction

    function automatic logic [7:0] branch_info_model(logic [7:0] start, logic taken,
                                                     logic misp, logic oor);
        logic [1:0] ctr;
        int         acc;
        int         thr;
        ctr = start[5:4];
        acc = int'(start[3:0]);
        thr = int'(`SIMPLE_BRANCH_ACCURACY_THRESHOLD);
        if (start[7:6] != COMPLEX_BRANCH && oor)
            return {COMPLEX_BRANCH, 2'b01, 4'h0};
        if (start[7:6] == INVALID || start[7:6] == JUMP)
            return {SIMPLE_BRANCH, taken ? 2'b11 : 2'b00, `SIMPLE_BRANCH_INIT_ACCURACY};
        if (start[7:6] == COMPLEX_BRANCH)
            return {COMPLEX_BRANCH, ctr, 4'h0};
        if (taken)
            ctr = (ctr == 2'b00) ? 2'b01 : 2'b11;
        else
            ctr = (ctr == 2'b11) ? 2'b10 : 2'b00;
        if (acc > thr)
            return {SIMPLE_BRANCH, ctr, 4'(acc - 1)};   // decay
        if (misp) begin
            acc = acc - int'(`SIMPLE_BRANCH_INACCURACY_PENALTY);
            if (acc < 0)
                return {COMPLEX_BRANCH, 2'b01, 4'h0};
            return {SIMPLE_BRANCH, ctr, 4'(acc)};
        end
        return {SIMPLE_BRANCH, ctr, 4'((acc >= thr) ? thr : acc + 1)};
    endfunction

    // ------------------------------
    // checks and stimulus

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_outputs();
        string n;
        n = exp_op.name();
        check_value("done_valid", 32'(exp_valid), 32'(done_valid));
        if (exp_valid) begin
            check_value({n, " taken"}, 32'(exp_taken), 32'(done_taken));
            check_value({n, " mispredict"}, 32'(exp_mispredict), 32'(done_mispredict));
            check_value({n, " out_of_range"}, 32'(exp_out_of_range), 32'(done_out_of_range));
            check_value({n, " target"}, exp_target, done_target);
            check_value({n, " pred_info"}, 32'(exp_info), 32'(updated_pred_info));
            if (!is_branch_op(exp_op))
                check_value({n, " link_value"}, exp_link, done_link_value);
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        int          idx;
        idx = int'($urandom() % 14);
        r   = $urandom();
        valid_in   = ($urandom() % 4) != 0;  // 75 percent issue rate
        op         = legal_ops[idx];
        pc         = $urandom() & 32'hFFFF_FFFE;
        rs1_data   = $urandom();
        rs2_data   = (($urandom() % 2) == 0) ? rs1_data : $urandom();
        imm        = (r[31:29] == 3'b000) ? $urandom() : {{20{r[11]}}, r[11:0]};
        is_link_ra = 1'($urandom());
        is_ret_ra  = 1'($urandom());
        start_pred_info = 8'($urandom());

        exp_valid  = valid_in;
        exp_op     = op;
        exp_taken  = model_taken(op, rs1_data, rs2_data);
        exp_target = model_target(op, pc, rs1_data, imm);
        if (op inside {JALR, JAL})
            exp_link = pc + 32'd4;
        else if (op inside {C_JALR, C_JAL, C_J, C_JR})
            exp_link = pc + 32'd2;
        else
            exp_link = exp_target;

        if (($urandom() % 2) == 0) begin  // frontend got it right
            pred_taken  = exp_taken;
            pred_target = exp_target;
        end else begin
            pred_taken  = 1'($urandom());
            pred_target = $urandom();
        end

        exp_mispredict = !(op inside {LUI, AUIPC}) && ((exp_taken != pred_taken)
                         || (exp_taken && (exp_target != pred_target)));
        exp_out_of_range = exp_target[`XLEN-1:`BRU_TARGET_RANGE_BITS]
                           != pc[`XLEN-1:`BRU_TARGET_RANGE_BITS];
        if (is_branch_op(op))
            exp_info = branch_info_model(start_pred_info, exp_taken, exp_mispredict,
                                         exp_out_of_range);
        else
            exp_info = jump_info_model(op, is_link_ra, is_ret_ra);
        if (valid_in)
            issued++;
    endtask

    initial begin
        seed_val  = $urandom(85264);
        legal_ops = '{JALR, C_JALR, JAL, C_JAL, C_J, C_JR, LUI, AUIPC,
                      BEQ, BNE, BLT, BGE, BLTU, BGEU};
        clk = 1'b0;
        arst_n = 1'b0;
        valid_in = 1'b0;
        op = JAL;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm = '0;
        is_link_ra = 1'b0;
        is_ret_ra = 1'b0;
        start_pred_info = '0;
        pred_taken = 1'b0;
        pred_target = '0;
        exp_valid = 1'b0;
        exp_op = JAL;
        errors = 0;
        issued = 0;
        cycles = 0;

        repeat (16) begin
            @(posedge clk);
            #2;
            check_value("reset done_valid", 32'd0, 32'(done_valid));
        end
        arst_n = 1'b1;

        while (issued < NUM_INSTR) begin
            @(posedge clk);
            #2;
            compare_outputs();
            drive_random();
        end
        @(posedge clk);
        #2;
        compare_outputs();  // last issued instruction

        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/core_types_pkg.sv
rtl/bru_branch_resolver.sv
rtl/bru_pred_info_updater.sv
rtl/bru_top.sv
sim/tb_bru_top.sv
